/* verilog/cpuTypesPkg.sv */
// shared types and encodings for the pipelined datapath
// stages and testbench refer to these by scoped name
`default_nettype none

package cpuTypesPkg;

  typedef logic [31:0] wordT;   // data or instruction word
  typedef logic [4:0]  regIdxT; // register index

  // primary opcode in instr[31:26]
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    ADDIU = 6'h09,
    ORI   = 6'h0D,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = 6'h3F
  } opcodeT;

  // r-type function field in instr[5:0]
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2A
  } functT;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT, // signed compare
    ALU_SLL,
    ALU_LUI  // immediate into upper half
  } aluOpT;

  localparam wordT HALT_WORD = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

/* verilog/registerFile.sv */
// 32 x 32 register file where r0 always reads zero
// writes show through on the read ports in the same cycle
`timescale 1ns/10ps
`default_nettype none

module registerFile (
  input  logic                CLK,
  input  logic                nRST,
  input  cpuTypesPkg::regIdxT rsel1,
  input  cpuTypesPkg::regIdxT rsel2,
  input  cpuTypesPkg::regIdxT wsel,
  input  logic                WEN,
  input  cpuTypesPkg::wordT   wdat,
  output cpuTypesPkg::wordT   rdat1,
  output cpuTypesPkg::wordT   rdat2
);

  cpuTypesPkg::wordT regs [32];
  logic              doWrite;

  assign doWrite = WEN && (wsel != 5'd0); // r0 never written

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (doWrite) begin
      regs[wsel] <= wdat;
    end
  end

  // bypass from writeback so a producer three slots ahead is seen
  assign rdat1 = (doWrite && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (doWrite && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

`default_nettype wire

/* verilog/decodeStage.sv */
// decode stage with the IF/ID register, control decode, register read and immediate
// unknown encodings come out as nops with all control low
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                advance,
  input  cpuTypesPkg::wordT   imemload,
  input  logic                regWrite,
  input  cpuTypesPkg::regIdxT wsel,
  input  cpuTypesPkg::wordT   wdat,
  output cpuTypesPkg::aluOpT  aluOp,
  output logic                aluSrc,
  output logic                shiftSel,
  output logic                idRegWrite,
  output logic                idMemRead,
  output logic                idMemWrite,
  output logic                idHalt,
  output cpuTypesPkg::wordT   rdat1,
  output cpuTypesPkg::wordT   rdat2,
  output cpuTypesPkg::wordT   extImm,
  output logic [4:0]          shamt,
  output cpuTypesPkg::regIdxT destReg
);

  cpuTypesPkg::wordT   instr;
  cpuTypesPkg::opcodeT opcode;
  cpuTypesPkg::functT  funct;
  logic                zeroExt;
  logic                regDst;

  // IF/ID resets to the all-zero word that acts as sll r0
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      instr <= '0;
    end else if (advance) begin
      instr <= imemload;
    end
  end

  assign opcode  = cpuTypesPkg::opcodeT'(instr[31:26]);
  assign funct   = cpuTypesPkg::functT'(instr[5:0]);
  assign shamt   = instr[10:6];
  assign extImm  = zeroExt ? {16'h0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
  assign destReg = regDst ? instr[15:11] : instr[20:16]; // rd or rt

  always_comb begin
    aluOp      = cpuTypesPkg::ALU_ADD;
    aluSrc     = 1'b0;
    shiftSel   = 1'b0;
    zeroExt    = 1'b0;
    regDst     = 1'b0;
    idRegWrite = 1'b0;
    idMemRead  = 1'b0;
    idMemWrite = 1'b0;
    idHalt     = 1'b0;
    case (opcode)
      cpuTypesPkg::RTYPE: begin
        regDst     = 1'b1;
        idRegWrite = 1'b1;
        case (funct)
          cpuTypesPkg::SLL: begin
            aluOp    = cpuTypesPkg::ALU_SLL;
            shiftSel = 1'b1; // shift amount from shamt
          end
          cpuTypesPkg::ADDU: aluOp = cpuTypesPkg::ALU_ADD;
          cpuTypesPkg::SUBU: aluOp = cpuTypesPkg::ALU_SUB;
          cpuTypesPkg::AND:  aluOp = cpuTypesPkg::ALU_AND;
          cpuTypesPkg::OR:   aluOp = cpuTypesPkg::ALU_OR;
          cpuTypesPkg::SLT:  aluOp = cpuTypesPkg::ALU_SLT;
          default:           idRegWrite = 1'b0;
        endcase
      end
      cpuTypesPkg::ADDIU: begin
        aluSrc     = 1'b1;
        idRegWrite = 1'b1;
      end
      cpuTypesPkg::ORI: begin
        aluOp      = cpuTypesPkg::ALU_OR;
        aluSrc     = 1'b1;
        zeroExt    = 1'b1;
        idRegWrite = 1'b1;
      end
      cpuTypesPkg::LUI: begin
        aluOp      = cpuTypesPkg::ALU_LUI;
        aluSrc     = 1'b1;
        zeroExt    = 1'b1;
        idRegWrite = 1'b1;
      end
      cpuTypesPkg::LW: begin
        aluSrc     = 1'b1; // base + offset
        idRegWrite = 1'b1;
        idMemRead  = 1'b1;
      end
      cpuTypesPkg::SW: begin
        aluSrc     = 1'b1;
        idMemWrite = 1'b1;
      end
      cpuTypesPkg::HALT: idHalt = (instr == cpuTypesPkg::HALT_WORD);
      default: ;
    endcase
  end

  registerFile regFile_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .rsel1 (instr[25:21]),
    .rsel2 (instr[20:16]),
    .wsel  (wsel),
    .WEN   (regWrite),
    .wdat  (wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
// execute stage holding the ID/EX register, operand B select and the ALU
// results and store data go on to the result stage
`timescale 1ns/10ps
`default_nettype none

module executeStage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                advance,
  input  cpuTypesPkg::aluOpT  aluOp,
  input  logic                aluSrc,
  input  logic                shiftSel,
  input  logic                idRegWrite,
  input  logic                idMemRead,
  input  logic                idMemWrite,
  input  logic                idHalt,
  input  cpuTypesPkg::wordT   rdat1,
  input  cpuTypesPkg::wordT   rdat2,
  input  cpuTypesPkg::wordT   extImm,
  input  logic [4:0]          shamt,
  input  cpuTypesPkg::regIdxT destReg,
  output logic                exRegWrite,
  output logic                exMemRead,
  output logic                exMemWrite,
  output logic                exHalt,
  output cpuTypesPkg::regIdxT exDest,
  output cpuTypesPkg::wordT   aluOut,
  output cpuTypesPkg::wordT   storeData
);

  cpuTypesPkg::aluOpT op;
  logic               useImm;
  logic               useShamt;
  cpuTypesPkg::wordT  opA;
  cpuTypesPkg::wordT  imm;
  logic [4:0]         shiftAmt;
  cpuTypesPkg::wordT  opB;

  // ID/EX control
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      exRegWrite <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exHalt     <= 1'b0;
    end else if (advance) begin
      exRegWrite <= idRegWrite;
      exMemRead  <= idMemRead;
      exMemWrite <= idMemWrite;
      exHalt     <= idHalt;
    end
  end

  // ID/EX operands
  always_ff @(posedge CLK) begin
    if (advance) begin
      op        <= aluOp;
      useImm    <= aluSrc;
      useShamt  <= shiftSel;
      opA       <= rdat1;
      storeData <= rdat2; // rt value that is also the sll source
      imm       <= extImm;
      shiftAmt  <= shamt;
      exDest    <= destReg;
    end
  end

  assign opB = useShamt ? 32'(shiftAmt) : (useImm ? imm : storeData);

  always_comb begin
    case (op)
      cpuTypesPkg::ALU_ADD: aluOut = opA + opB;
      cpuTypesPkg::ALU_SUB: aluOut = opA - opB;
      cpuTypesPkg::ALU_AND: aluOut = opA & opB;
      cpuTypesPkg::ALU_OR:  aluOut = opA | opB;
      cpuTypesPkg::ALU_SLT: aluOut = {31'h0, $signed(opA) < $signed(opB)};
      cpuTypesPkg::ALU_SLL: aluOut = storeData << opB[4:0];
      cpuTypesPkg::ALU_LUI: aluOut = {opB[15:0], 16'h0};
      default:              aluOut = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/resultStage.sv */
// memory and writeback where EX/MEM drives the data port and MEM/WB the register write
// also keeps the sticky halt flag
`timescale 1ns/10ps
`default_nettype none

module resultStage (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                advance,
  input  logic                exRegWrite,
  input  logic                exMemRead,
  input  logic                exMemWrite,
  input  logic                exHalt,
  input  cpuTypesPkg::regIdxT exDest,
  input  cpuTypesPkg::wordT   aluOut,
  input  cpuTypesPkg::wordT   storeData,
  input  cpuTypesPkg::wordT   dmemload,
  output logic                dmemREN,
  output logic                dmemWEN,
  output cpuTypesPkg::wordT   dmemaddr,
  output cpuTypesPkg::wordT   dmemstore,
  output logic                regWrite,
  output cpuTypesPkg::regIdxT wsel,
  output cpuTypesPkg::wordT   wdat,
  output logic                halt
);

  logic                memRegWrite;
  logic                memHalt;
  cpuTypesPkg::regIdxT memDest;

  // EX/MEM and MEM/WB control with halt set as the marker enters MEM/WB
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      dmemREN     <= 1'b0;
      dmemWEN     <= 1'b0;
      memRegWrite <= 1'b0;
      memHalt     <= 1'b0;
      regWrite    <= 1'b0;
      halt        <= 1'b0;
    end else if (advance) begin
      dmemREN     <= exMemRead;
      dmemWEN     <= exMemWrite;
      memRegWrite <= exRegWrite;
      memHalt     <= exHalt;
      regWrite    <= memRegWrite;
      halt        <= halt | memHalt; // stays up until reset
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      dmemaddr  <= aluOut;
      dmemstore <= storeData;
      memDest   <= exDest;
      wsel      <= memDest;
      wdat      <= dmemREN ? dmemload : dmemaddr; // load data or alu result
    end
  end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
// top of the five-stage pipeline with the pc, global advance and stage wiring
// advance freezes everything while ihit is low or a data access waits for dhit
`timescale 1ns/10ps
`default_nettype none

module datapath #(
  parameter cpuTypesPkg::wordT PC_INIT = 32'h0
) (
  input  logic              CLK,
  input  logic              nRST,
  input  cpuTypesPkg::wordT imemload,
  input  logic              ihit,
  input  cpuTypesPkg::wordT dmemload,
  input  logic              dhit,
  output logic              imemREN,
  output cpuTypesPkg::wordT imemaddr,
  output logic              dmemREN,
  output logic              dmemWEN,
  output cpuTypesPkg::wordT dmemaddr,
  output cpuTypesPkg::wordT dmemstore,
  output logic              halt
);

  cpuTypesPkg::wordT   pc;
  logic                advance;

  cpuTypesPkg::aluOpT  aluOp;
  logic                aluSrc, shiftSel;
  logic                idRegWrite, idMemRead, idMemWrite, idHalt;
  cpuTypesPkg::wordT   rdat1, rdat2, extImm;
  logic [4:0]          shamt;
  cpuTypesPkg::regIdxT destReg;

  logic                exRegWrite, exMemRead, exMemWrite, exHalt;
  cpuTypesPkg::regIdxT exDest;
  cpuTypesPkg::wordT   aluOut, storeData;

  logic                regWrite;
  cpuTypesPkg::regIdxT wsel;
  cpuTypesPkg::wordT   wdat;

  // hold while fetch misses or a data access is still outstanding
  assign advance  = ihit & ~((dmemREN | dmemWEN) & ~dhit);
  assign imemREN  = ~halt;
  assign imemaddr = pc;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (advance && !halt) begin
      pc <= pc + 32'd4; // always sequential as there are no branches
    end
  end

  decodeStage decode_i (
    .CLK(CLK), .nRST(nRST), .advance(advance), .imemload(imemload),
    .regWrite(regWrite), .wsel(wsel), .wdat(wdat),
    .aluOp(aluOp), .aluSrc(aluSrc), .shiftSel(shiftSel),
    .idRegWrite(idRegWrite), .idMemRead(idMemRead), .idMemWrite(idMemWrite),
    .idHalt(idHalt), .rdat1(rdat1), .rdat2(rdat2), .extImm(extImm),
    .shamt(shamt), .destReg(destReg)
  );

  executeStage execute_i (
    .CLK(CLK), .nRST(nRST), .advance(advance),
    .aluOp(aluOp), .aluSrc(aluSrc), .shiftSel(shiftSel),
    .idRegWrite(idRegWrite), .idMemRead(idMemRead), .idMemWrite(idMemWrite),
    .idHalt(idHalt), .rdat1(rdat1), .rdat2(rdat2), .extImm(extImm),
    .shamt(shamt), .destReg(destReg),
    .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
    .exHalt(exHalt), .exDest(exDest), .aluOut(aluOut), .storeData(storeData)
  );

  resultStage result_i (
    .CLK(CLK), .nRST(nRST), .advance(advance),
    .exRegWrite(exRegWrite), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
    .exHalt(exHalt), .exDest(exDest), .aluOut(aluOut), .storeData(storeData),
    .dmemload(dmemload), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .regWrite(regWrite), .wsel(wsel), .wdat(wdat), .halt(halt)
  );

endmodule

`default_nettype wire

/* test/clockGen.sv */
// clock and reset source for the datapath testbench
// 8 ns clock with nRST low for 5 cycles at start and after each restart request
`timescale 1ns/10ps
`default_nettype none

module clockGen (
  input  logic rstReq,
  output logic CLK,
  output logic nRST
);

  logic clk = 1'b0;
  logic rstN = 1'b0;
  int   lowCycles = 0;

  always #4 clk = ~clk;

  assign CLK  = clk;
  assign nRST = rstN;

  always @(posedge clk) begin
    if (rstReq) begin
      rstN      <= 1'b0;
      lowCycles <= 0;
    end else if (!rstN) begin
      lowCycles <= lowCycles + 1;
      if (lowCycles == 4) rstN <= 1'b1; // release on the fifth edge
    end
  end

endmodule

`default_nettype wire

/* test/datapathTb.sv */
// testbench for the pipelined datapath that runs one program with and without memory gaps
// every store is checked against a table built from the instruction rules
`timescale 1ns/10ps
`default_nettype none

module datapathTb;

  logic              CLK;
  logic              nRST;
  logic              rstReq = 1'b0;
  cpuTypesPkg::wordT imemload = '0;
  logic              ihit = 1'b0;
  cpuTypesPkg::wordT dmemload = '0;
  logic              dhit = 1'b0;
  logic              imemREN, dmemREN, dmemWEN, halt;
  cpuTypesPkg::wordT imemaddr, dmemaddr, dmemstore;

  cpuTypesPkg::wordT progMem [256];
  cpuTypesPkg::wordT dataMem [256];
  cpuTypesPkg::wordT expAddr [$];
  cpuTypesPkg::wordT expData [$];
  int                progLen = 0;
  int                storeIdx = 0;
  int                errorCount = 0;
  int                testsRun = 0;
  int                testsFailed = 0;
  logic              gapsOn = 1'b0;
  logic [7:0]        lfsr = 8'd82;
  logic [1:0]        iGap = '0;
  logic [1:0]        dGap = '0;

  clockGen clockGen_i (.rstReq(rstReq), .CLK(CLK), .nRST(nRST));

  datapath #(.PC_INIT(32'h0)) dut_i (
    .CLK(CLK), .nRST(nRST), .imemload(imemload), .ihit(ihit),
    .dmemload(dmemload), .dhit(dhit), .imemREN(imemREN), .imemaddr(imemaddr),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .halt(halt)
  );

  function automatic cpuTypesPkg::wordT iType(input cpuTypesPkg::opcodeT op,
      input cpuTypesPkg::regIdxT rs, input cpuTypesPkg::regIdxT rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic cpuTypesPkg::wordT rType(input cpuTypesPkg::functT fn,
      input cpuTypesPkg::regIdxT rs, input cpuTypesPkg::regIdxT rt,
      input cpuTypesPkg::regIdxT rd, input logic [4:0] shamt);
    return {cpuTypesPkg::RTYPE, rs, rt, rd, shamt, fn};
  endfunction

  // preload word for each byte address of data memory
  function automatic cpuTypesPkg::wordT fillWord(input cpuTypesPkg::wordT addr);
    return (addr * 32'h0001_0003) ^ 32'hC0DE_0000;
  endfunction

  // gap length 0..3 from two lfsr steps
  function automatic logic [1:0] drawGap();
    logic [1:0] bits;
    bits = '0;
    for (int i = 0; i < 2; i++) begin
      lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]}; // x^8+x^6+x^5+x^4+1
      bits = {bits[0], lfsr[0]};
    end
    return bits;
  endfunction

  task automatic compareValue(input string name, input cpuTypesPkg::wordT got,
      input cpuTypesPkg::wordT expected);
    if (got !== expected) begin
      $display("FAILED %s: got %h, expected %h", name, got, expected);
      errorCount++;
    end
  endtask

  // two nops after every instruction keep producers three slots ahead
  task automatic put(input cpuTypesPkg::wordT word);
    progMem[8'(progLen)]     = word;
    progMem[8'(progLen + 1)] = '0;
    progMem[8'(progLen + 2)] = '0;
    progLen += 3;
  endtask

  task automatic buildProgram();
    cpuTypesPkg::wordT   r1, r2, r3;
    cpuTypesPkg::regIdxT srcReg [12];
    cpuTypesPkg::wordT   srcVal [12];
    r1 = 32'hFFFF_FFF9; // -7 after sign extension
    r2 = 32'h0000_8005; // ori zero extends
    r3 = 32'h1234_0000; // lui
    for (int i = 0; i < 256; i++) begin
      progMem[8'(i)] = '0;
    end
    put(iType(cpuTypesPkg::ADDIU, 5'd0, 5'd1, 16'hFFF9));
    put(iType(cpuTypesPkg::ORI, 5'd0, 5'd2, 16'h8005));
    put(iType(cpuTypesPkg::LUI, 5'd0, 5'd3, 16'h1234));
    put(iType(cpuTypesPkg::ADDIU, 5'd0, 5'd4, 16'h0040)); // store base
    put(rType(cpuTypesPkg::ADDU, 5'd1, 5'd2, 5'd5, 5'd0));
    put(rType(cpuTypesPkg::SUBU, 5'd2, 5'd1, 5'd6, 5'd0));
    put(rType(cpuTypesPkg::AND, 5'd1, 5'd2, 5'd7, 5'd0));
    put(rType(cpuTypesPkg::OR, 5'd2, 5'd3, 5'd8, 5'd0));
    put(rType(cpuTypesPkg::SLT, 5'd1, 5'd2, 5'd9, 5'd0));  // negative vs positive
    put(rType(cpuTypesPkg::SLT, 5'd2, 5'd1, 5'd10, 5'd0));
    put(rType(cpuTypesPkg::SLL, 5'd0, 5'd2, 5'd11, 5'd4));
    put(iType(cpuTypesPkg::LW, 5'd0, 5'd12, 16'h0080));
    put(iType(cpuTypesPkg::ADDIU, 5'd0, 5'd0, 16'h0055)); // r0 stays zero
    srcReg = '{5'd1, 5'd2, 5'd3, 5'd5, 5'd6, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd0};
    srcVal = '{r1, r2, r3, r1 + r2, r2 - r1, r1 & r2, r2 | r3,
               32'h1, 32'h0, // signed -7 is below 0x8005
               r2 << 4, fillWord(32'h80), 32'h0};
    for (int k = 0; k < 12; k++) begin
      put(iType(cpuTypesPkg::SW, 5'd4, srcReg[4'(k)], 16'(4 * k)));
      expAddr.push_back(32'h40 + 32'(4 * k));
      expData.push_back(srcVal[4'(k)]);
    end
    put(cpuTypesPkg::HALT_WORD);
  endtask

  task automatic waitCycle();
    @(posedge CLK);
    #2;
  endtask

  // a store completes on the edge where dhit and ihit are both up
  task automatic recordStore();
    if (dmemWEN && dhit && ihit) begin
      if (storeIdx < expAddr.size()) begin
        compareValue("dmemaddr", dmemaddr, expAddr[storeIdx]);
        compareValue("dmemstore", dmemstore, expData[storeIdx]);
      end else begin
        $display("store number %0d to %h was not expected", storeIdx, dmemaddr);
        errorCount++;
      end
      dataMem[dmemaddr[9:2]] = dmemstore;
      storeIdx++;
    end
  endtask

  task automatic finishTest(input string name, input string runName, input int mark);
    testsRun++;
    if (errorCount == mark) begin
      $display("test %s, %s: passed", name, runName);
    end else begin
      $display("test %s, %s: failed with %0d errors", name, runName, errorCount - mark);
      testsFailed++;
    end
  endtask

  // memory models that answer 1 ns after the rising edge
  always begin
    @(posedge CLK);
    #1;
    if (!nRST) begin
      ihit = 1'b0;
      dhit = 1'b0;
      iGap = '0;
      dGap = '0;
    end else begin
      if (iGap != 2'd0) begin
        ihit = 1'b0;
        iGap = iGap - 2'd1;
      end else begin
        ihit = imemREN;
        if (gapsOn && imemREN) iGap = drawGap();
      end
      if (dGap != 2'd0) begin
        dhit = 1'b0;
        dGap = dGap - 2'd1;
      end else begin
        dhit = dmemREN | dmemWEN;
        if (gapsOn && dhit) dGap = drawGap();
      end
    end
    imemload = progMem[imemaddr[9:2]];
    dmemload = dmemREN ? dataMem[dmemaddr[9:2]] : '0;
  end

  initial begin
    int    mark;
    int    waited;
    string runName;
    buildProgram();
    for (int run = 0; run < 2; run++) begin
      gapsOn = (run == 1);
      if (gapsOn) runName = "random gaps";
      else runName = "no gaps";
      for (int i = 0; i < 256; i++) begin
        dataMem[8'(i)] = fillWord(32'(i) << 2);
      end
      storeIdx = 0;

      mark   = errorCount;
      rstReq = 1'b1;
      waitCycle();
      rstReq = 1'b0;
      waited = 0;
      while (!nRST && waited < 20) begin
        waitCycle();
        waited++;
      end
      if (!nRST) begin
        $display("reset was never released");
        errorCount++;
      end
      compareValue("halt", 32'(halt), 32'h0);
      compareValue("dmemREN", 32'(dmemREN), 32'h0);
      compareValue("dmemWEN", 32'(dmemWEN), 32'h0);
      compareValue("imemREN", 32'(imemREN), 32'h1);
      compareValue("imemaddr", imemaddr, 32'h0);
      finishTest("reset state", runName, mark);

      mark   = errorCount;
      waited = 0;
      while (!halt && waited < 4000) begin
        waitCycle();
        recordStore();
        waited++;
      end
      if (!halt) begin
        $display("timed out waiting for halt");
        errorCount++;
      end
      compareValue("store count", 32'(storeIdx), 32'(expAddr.size()));
      finishTest("store sequence", runName, mark);

      mark = errorCount;
      repeat (24) begin
        waitCycle();
        recordStore();
        compareValue("halt", 32'(halt), 32'h1);
        compareValue("imemREN", 32'(imemREN), 32'h0);
        compareValue("dmemWEN", 32'(dmemWEN), 32'h0);
      end
      compareValue("store count", 32'(storeIdx), 32'(expAddr.size()));
      finishTest("halt", runName, mark);
    end
    $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
verilog/cpuTypesPkg.sv
verilog/registerFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/datapath.sv
test/clockGen.sv
test/datapathTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the datapath testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module datapathTb -f compile.f \
  && ./obj_dir/VdatapathTb | tee /dev/stderr | grep -qx "NO ERRORS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
